// File: verilog/pkt_width_pkg.sv
// width constants, position tag enum, input byte and packet word structs

package pkt_width_pkg;

    //************************************************************************
    //  widths
    //************************************************************************
    localparam int BYTE_W     = 8;
    localparam int WORD_BYTES = 16;
    localparam int DATA_W     = BYTE_W * WORD_BYTES;   // 128
    localparam int BCNT_W     = 4;                     // byte position / invalid count
    localparam int BUFID_W    = 9;

    //************************************************************************
    //  types
    //************************************************************************
    // position of a word inside its packet
    typedef enum logic [1:0] {
        TAG_FIRST  = 2'b01,
        TAG_MIDDLE = 2'b11,
        TAG_LAST   = 2'b10
    } pos_tag_e;

    // one input byte with its packet marker
    typedef struct packed {
        logic              marker;    // opens or closes a packet
        logic [BYTE_W-1:0] data;
    } pkt_byte_t;

    // 134-bit packet word
    typedef struct packed {
        pos_tag_e          tag;
        logic [BCNT_W-1:0] inv_cnt;   // unused bytes at the low end
        logic [DATA_W-1:0] data;      // first byte in the top slot
    } pkt_word_t;

endpackage

// File: verilog/byte_word_packer.sv
// packet tracking, byte placement into words, word header generation
`timescale 1ns/1ps

module byte_word_packer import pkt_width_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_data_wr,      // byte strobe
    input  pkt_byte_t iv_byte,
    output logic      o_word_vld,     // one cycle per finished word
    output pkt_word_t ov_word,
    output logic      o_word_first    // word holds the opening byte
);

    //************************************************************************
    //  state
    //************************************************************************
    logic              pkt_open;       // between opening and closing byte
    logic              word_has_open;  // current word got the opening byte
    logic [BCNT_W-1:0] byte_pos;       // next free slot
    logic [DATA_W-1:0] asm_data;       // word under assembly

    logic              open_byte;
    logic              close_byte;
    logic              byte_take;
    logic              word_done;
    logic [DATA_W-1:0] slot_data;
    pos_tag_e          word_tag;
    logic [BCNT_W-1:0] word_inv;

    //************************************************************************
    //  byte classification
    //************************************************************************
    assign open_byte  = i_data_wr && !pkt_open && iv_byte.marker;
    assign close_byte = i_data_wr && pkt_open && iv_byte.marker;

    // marker-less bytes outside a packet fall through here
    assign byte_take  = open_byte || (i_data_wr && pkt_open);

    assign word_done  = byte_take && (close_byte || byte_pos == BCNT_W'(WORD_BYTES - 1));

    // msb first so slot 0 is the top byte
    always_comb begin
        slot_data = asm_data;
        slot_data[DATA_W - 1 - byte_pos * BYTE_W -: BYTE_W] = iv_byte.data;
    end

    //************************************************************************
    //  word header
    //************************************************************************
    always_comb begin
        if (close_byte) begin
            word_tag = TAG_LAST;                // wins over first on one-word packets
        end
        else if (word_has_open) begin
            word_tag = TAG_FIRST;
        end
        else begin
            word_tag = TAG_MIDDLE;
        end
    end

    assign word_inv = ~byte_pos;                // 16 - (pos + 1) taken mod 16

    //************************************************************************
    //  packet tracking and assembly
    //************************************************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pkt_open      <= 1'b0;
            word_has_open <= 1'b0;
            byte_pos      <= '0;
            asm_data      <= '0;
        end
        else begin
            if (open_byte) begin
                pkt_open <= 1'b1;
            end
            else if (close_byte) begin
                pkt_open <= 1'b0;
            end

            if (open_byte) begin
                word_has_open <= 1'b1;
            end
            else if (word_done) begin
                word_has_open <= 1'b0;
            end

            if (word_done) begin
                byte_pos <= '0;
                asm_data <= '0;                 // unused slots of the next word stay zero
            end
            else if (byte_take) begin
                byte_pos <= byte_pos + 1'b1;
                asm_data <= slot_data;
            end
        end
    end

    //************************************************************************
    //  word output
    //************************************************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_word_vld   <= 1'b0;
            o_word_first <= 1'b0;
            ov_word      <= '0;
        end
        else begin
            o_word_vld <= word_done;
            if (word_done) begin
                ov_word.tag     <= word_tag;
                ov_word.inv_cnt <= word_inv;
                ov_word.data    <= slot_data;
                o_word_first    <= word_has_open;
            end
        end
    end

    // back-to-back words only when a full word is followed by the closing byte
    a_word_spacing : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_word_vld |=> (!o_word_vld || ov_word.tag == TAG_LAST)
    );

endmodule

// File: verilog/pkt_lane_output.sv
// alternating lane registers, lane write pulses, buffer id latch
`timescale 1ns/1ps

module pkt_lane_output import pkt_width_pkg::*; (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_word_vld,
    input  pkt_word_t          iv_word,
    input  logic               i_word_first,     // restart at lane 1
    input  logic               i_pkt_bufid_wr,
    input  logic [BUFID_W-1:0] iv_bufid,
    output pkt_word_t          ov_data1,
    output pkt_word_t          ov_data2,
    output logic               o_data1_write_flag,
    output logic               o_data2_write_flag,
    output logic [BUFID_W-1:0] ov_bufid
);

    logic lane2_next;   // next word goes to lane 2
    logic use_lane2;

    assign use_lane2 = i_word_first ? 1'b0 : lane2_next;

    //************************************************************************
    //  lane select and lane registers
    //************************************************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lane2_next         <= 1'b0;
            o_data1_write_flag <= 1'b0;
            o_data2_write_flag <= 1'b0;
            ov_data1           <= '0;
            ov_data2           <= '0;
        end
        else begin
            o_data1_write_flag <= i_word_vld && !use_lane2;
            o_data2_write_flag <= i_word_vld && use_lane2;
            if (i_word_vld) begin
                lane2_next <= !use_lane2;
                if (use_lane2) begin
                    ov_data2 <= iv_word;
                end
                else begin
                    ov_data1 <= iv_word;            // other lane holds its word
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ov_bufid <= '0;
        end
        else if (i_pkt_bufid_wr) begin
            ov_bufid <= iv_bufid;
        end
    end

    a_one_lane : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(o_data1_write_flag && o_data2_write_flag)
    );

endmodule

// File: verilog/pkt_width_transfer.sv
// top level wiring the byte packer to the two-lane output stage
`timescale 1ns/1ps

module pkt_width_transfer import pkt_width_pkg::*; (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_data_wr,
    input  pkt_byte_t          iv_byte,
    input  logic               i_pkt_bufid_wr,
    input  logic [BUFID_W-1:0] iv_bufid,
    output pkt_word_t          ov_data1,
    output logic               o_data1_write_flag,
    output pkt_word_t          ov_data2,
    output logic               o_data2_write_flag,
    output logic [BUFID_W-1:0] ov_bufid
);

    pkt_word_t word;        // finished word
    logic      word_vld;
    logic      word_first;

    byte_word_packer u_packer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_data_wr    (i_data_wr),
        .iv_byte      (iv_byte),
        .o_word_vld   (word_vld),
        .ov_word      (word),
        .o_word_first (word_first)
    );

    pkt_lane_output u_lane_out (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_word_vld         (word_vld),
        .iv_word            (word),
        .i_word_first       (word_first),
        .i_pkt_bufid_wr     (i_pkt_bufid_wr),
        .iv_bufid           (iv_bufid),
        .ov_data1           (ov_data1),
        .ov_data2           (ov_data2),
        .o_data1_write_flag (o_data1_write_flag),
        .o_data2_write_flag (o_data2_write_flag),
        .ov_bufid           (ov_bufid)
    );

endmodule

// File: verification/pkt_width_checker.sv
// reference packing model, lane order and timing checks, buffer id check, error counts
`timescale 1ns/1ps

module pkt_width_checker import pkt_width_pkg::*; (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_data_wr,
    input  pkt_byte_t          iv_byte,
    input  logic               i_pkt_bufid_wr,
    input  logic [BUFID_W-1:0] iv_bufid,
    input  pkt_word_t          iv_data1,
    input  pkt_word_t          iv_data2,
    input  logic               i_data1_write_flag,
    input  logic               i_data2_write_flag,
    input  logic [BUFID_W-1:0] iv_bufid_out,
    output int                 o_data_errs,
    output int                 o_order_errs,
    output int                 o_bufid_errs,
    output int                 o_words_seen,
    output int                 o_pending
);

    typedef struct packed {
        logic        lane2;     // expected on lane 2
        logic [31:0] due;       // sample cycle of the write flag
        pkt_word_t   word;
    } exp_word_t;

    exp_word_t          exp_q[$];
    logic [BYTE_W-1:0]  cur_bytes[$];   // bytes of the word being collected
    logic               pkt_open;
    logic               has_open;       // current word holds the opening byte
    int                 word_idx;       // words already finished in this packet
    logic [31:0]        cycle;
    pkt_word_t          held1;
    pkt_word_t          held2;
    logic [BUFID_W-1:0] exp_bufid;

    //************************************************************************
    //  reference model
    //************************************************************************
    function automatic pkt_word_t build_word(input logic last, input logic first);
        pkt_word_t         w;
        logic [BYTE_W-1:0] b;
        int                n;
        n      = cur_bytes.size();
        w.data = '0;
        for (int i = 0; i < WORD_BYTES; i++) begin
            b      = (i < n) ? cur_bytes[i] : 8'h00;    // unused bytes are zero
            w.data = {w.data[DATA_W-BYTE_W-1:0], b};
        end
        if (last) begin
            w.tag = TAG_LAST;
        end
        else if (first) begin
            w.tag = TAG_FIRST;
        end
        else begin
            w.tag = TAG_MIDDLE;
        end
        w.inv_cnt = BCNT_W'((WORD_BYTES - n) % WORD_BYTES);
        return w;
    endfunction

    task automatic finish_word(input logic last);
        exp_word_t e;
        e.word  = build_word(last, has_open);
        e.lane2 = word_idx[0];                          // lane 1 on even words
        e.due   = cycle + 32'd2;
        exp_q.push_back(e);
        word_idx = word_idx + 1;
        has_open = 1'b0;
        cur_bytes.delete();
    endtask

    task automatic take_byte(input pkt_byte_t b);
        if (!pkt_open) begin
            if (b.marker) begin
                pkt_open = 1'b1;
                has_open = 1'b1;
                word_idx = 0;
                cur_bytes.delete();
                cur_bytes.push_back(b.data);
            end
        end
        else begin
            cur_bytes.push_back(b.data);
            if (b.marker) begin
                pkt_open = 1'b0;
                finish_word(1'b1);
            end
            else if (cur_bytes.size() == WORD_BYTES) begin
                finish_word(1'b0);
            end
        end
    endtask

    //************************************************************************
    //  lane comparison
    //************************************************************************
    task automatic check_lane(input int lane, input pkt_word_t actual);
        exp_word_t e;
        string     name;
        name = (lane == 1) ? "lane1_word" : "lane2_word";
        o_words_seen++;
        if (exp_q.size() == 0) begin
            $display("ERROR: unexpected word on lane %0d at cycle %0d", lane, cycle);
            o_order_errs++;
        end
        else begin
            e = exp_q.pop_front();
            if (e.due != cycle) begin
                $display("ERROR: lane %0d written at cycle %0d, expected at cycle %0d",
                         lane, cycle, e.due);
                o_order_errs++;
            end
            if (e.lane2 != (lane == 2)) begin
                $display("ERROR: word written to lane %0d at cycle %0d, wrong lane",
                         lane, cycle);
                o_order_errs++;
            end
            if (actual !== e.word) begin
                $display("FAILED %s: expected %h, actual %h", name, e.word, actual);
                o_data_errs++;
            end
        end
    endtask

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            exp_q.delete();
            cur_bytes.delete();
            pkt_open  = 1'b0;
            has_open  = 1'b0;
            word_idx  = 0;
            cycle     = '0;
            held1     = '0;
            held2     = '0;
            exp_bufid = '0;
        end
        else begin
            cycle = cycle + 32'd1;
            if (i_data1_write_flag && i_data2_write_flag) begin
                $display("ERROR: both lane write flags high at cycle %0d", cycle);
                o_order_errs++;
            end
            if (i_data1_write_flag) begin
                check_lane(1, iv_data1);
                held1 = iv_data1;
            end
            else if (iv_data1 !== held1) begin          // lane must hold
                $display("FAILED lane1_hold: expected %h, actual %h", held1, iv_data1);
                o_data_errs++;
                held1 = iv_data1;
            end
            if (i_data2_write_flag) begin
                check_lane(2, iv_data2);
                held2 = iv_data2;
            end
            else if (iv_data2 !== held2) begin
                $display("FAILED lane2_hold: expected %h, actual %h", held2, iv_data2);
                o_data_errs++;
                held2 = iv_data2;
            end
            while (exp_q.size() > 0 && exp_q[0].due <= cycle) begin
                $display("ERROR: word due at cycle %0d was never written", exp_q[0].due);
                o_order_errs++;
                exp_q.delete(0);
            end
            if (iv_bufid_out !== exp_bufid) begin
                $display("FAILED bufid: expected %h, actual %h", exp_bufid, iv_bufid_out);
                o_bufid_errs++;
                exp_bufid = iv_bufid_out;
            end
            if (i_pkt_bufid_wr) begin
                exp_bufid = iv_bufid;                   // visible at the next sample
            end
            if (i_data_wr) begin
                take_byte(iv_byte);
            end
        end
        o_pending = exp_q.size();
    end

endmodule

// File: verification/tb_pkt_width_transfer.sv
// clock, reset, seeded random packet and buffer id stimulus, watchdog, DUT and checker instances
`timescale 1ns/1ps

module tb_pkt_width_transfer import pkt_width_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 10;
    localparam int N_PKTS      = 300;
    localparam int MIN_LEN     = 2;
    localparam int MAX_LEN     = 50;
    localparam int MAX_GAP     = 2;     // idle cycles after a packet byte
    localparam int MAX_STRAY   = 3;     // marker-less bytes between packets
    localparam int MAX_IDLE    = 4;
    localparam int LONGEST_CYC = (MAX_LEN + MAX_STRAY) * (MAX_GAP + 1) + MAX_IDLE;
    localparam int TIMEOUT_NS  = 2 * N_PKTS * LONGEST_CYC * CLK_PERIOD;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               data_wr;
    pkt_byte_t          byte_in;
    logic               bufid_wr;
    logic [BUFID_W-1:0] bufid;
    pkt_word_t          data1;
    pkt_word_t          data2;
    logic               flag1;
    logic               flag2;
    logic [BUFID_W-1:0] bufid_out;

    int                 data_errs;
    int                 order_errs;
    int                 bufid_errs;
    int                 words_seen;
    int                 pending;
    integer             seed = 32'h2ed8_f44c;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pkt_width_transfer u_pkt_width_transfer (
        .i_clk              (clk),
        .i_rst_n            (rst_n),
        .i_data_wr          (data_wr),
        .iv_byte            (byte_in),
        .i_pkt_bufid_wr     (bufid_wr),
        .iv_bufid           (bufid),
        .ov_data1           (data1),
        .o_data1_write_flag (flag1),
        .ov_data2           (data2),
        .o_data2_write_flag (flag2),
        .ov_bufid           (bufid_out)
    );

    pkt_width_checker u_checker (
        .i_clk              (clk),
        .i_rst_n            (rst_n),
        .i_data_wr          (data_wr),
        .iv_byte            (byte_in),
        .i_pkt_bufid_wr     (bufid_wr),
        .iv_bufid           (bufid),
        .iv_data1           (data1),
        .iv_data2           (data2),
        .i_data1_write_flag (flag1),
        .i_data2_write_flag (flag2),
        .iv_bufid_out       (bufid_out),
        .o_data_errs        (data_errs),
        .o_order_errs       (order_errs),
        .o_bufid_errs       (bufid_errs),
        .o_words_seen       (words_seen),
        .o_pending          (pending)
    );

    //************************************************************************
    //  stimulus helpers
    //************************************************************************
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // one clock of stimulus with an occasional buffer id write
    task automatic drive_cycle(input logic wr, input pkt_byte_t b);
        @(posedge clk);
        data_wr  <= wr;
        byte_in  <= b;
        bufid_wr <= (rand_below(8) == 0);
        bufid    <= BUFID_W'($random(seed));
    endtask

    task automatic send_packet(input int len);
        pkt_byte_t b;
        int        gap;
        for (int i = 0; i < len; i++) begin
            b.marker = (i == 0) || (i == len - 1);      // open and close
            b.data   = BYTE_W'($random(seed));
            drive_cycle(1'b1, b);
            gap = (rand_below(4) == 0) ? 1 + rand_below(MAX_GAP) : 0;
            repeat (gap) drive_cycle(1'b0, '0);
        end
    endtask

    task automatic send_strays(input int n);
        pkt_byte_t b;
        for (int i = 0; i < n; i++) begin
            b.marker = 1'b0;
            b.data   = BYTE_W'($random(seed));
            drive_cycle(1'b1, b);
        end
    endtask

    task automatic print_counts();
        $display("errors: data %0d, lane/timing %0d, bufid %0d, words checked %0d",
                 data_errs, order_errs, bufid_errs, words_seen);
    endtask

    //************************************************************************
    //  main sequence
    //************************************************************************
    initial begin
        int directed[6] = '{2, 16, 17, 32, 15, 48};     // header corner cases first
        int len;
        int errs;
        rst_n    = 1'b0;
        data_wr  = 1'b0;
        byte_in  = '0;
        bufid_wr = 1'b0;
        bufid    = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        for (int p = 0; p < N_PKTS; p++) begin
            if (p < 6) begin
                len = directed[p];
            end
            else begin
                len = MIN_LEN + rand_below(MAX_LEN - MIN_LEN + 1);
            end
            send_packet(len);
            send_strays(rand_below(MAX_STRAY + 1));
            repeat (rand_below(MAX_IDLE + 1)) drive_cycle(1'b0, '0);
        end
        drive_cycle(1'b0, '0);
        repeat (2) @(posedge clk);
        wait (pending == 0);                            // last words written
        repeat (4) @(posedge clk);

        errs = data_errs + order_errs + bufid_errs;
        if (words_seen == 0) begin
            $display("ERROR: no words were seen on either lane");
            errs++;
        end
        print_counts();
        if (errs == 0) begin
            $display("Finished with no errors");
        end
        else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: timeout after %0d ns, the run did not finish", TIMEOUT_NS);
        print_counts();
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: all.f
verilog/pkt_width_pkg.sv
verilog/byte_word_packer.sv
verilog/pkt_lane_output.sv
verilog/pkt_width_transfer.sv
verification/pkt_width_checker.sv
verification/tb_pkt_width_transfer.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the packet width transfer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f all.f \
    --top-module tb_pkt_width_transfer \
    -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_pkt_width_transfer)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
